// File: design/link_config.svh
/* build-time constants for the serial channel end
   include wherever FIFO depth, CC timing or idle framing is needed */
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

// FIFO depth in words, keep a power of two so pointers wrap
`define LINK_FIFO_DEPTH 16

// cycles between CC words, same role as the standard CC module period
`define LINK_CC_PERIOD 64

// good idles in a row before the lane counts as up
`define LINK_LANE_UP_COUNT 8

// 34-bit pattern carried by every idle word
`define LINK_IDLE_PATTERN 34'h2_BC5A_3C7D

`endif

// File: design/link_pkg.sv
/* lane word layout shared by framer, deframer and top level
   one 37-bit payload is read either as data or as a control word */
package link_pkg;

  // control word kinds, every other code is illegal on the lane
  typedef enum logic [2:0] {
    IDLE = 3'b001,
    CC   = 3'b010
  } ctrl_kind_e;

  typedef struct packed {
    logic        last;
    logic [3:0]  keep;
    logic [31:0] data;
  } lane_data_t;

  typedef struct packed {
    ctrl_kind_e  kind;
    logic [33:0] info;                  // idle pattern or don't care
  } lane_ctrl_t;

  // same bits, meaning picked by is_ctrl
  typedef union packed {
    lane_data_t data;
    lane_ctrl_t ctrl;
  } lane_payload_u;

  typedef struct packed {
    logic          is_ctrl;
    lane_payload_u payload;
  } lane_word_t;

endpackage

// File: design/axis_if.sv
/* AXI4-Stream bundle between blocks of the channel
   src drives the word, snk answers with tready */
`timescale 1ns/100ps

interface axis_if;
  logic [31:0] tdata;
  logic [3:0]  tkeep;
  logic        tlast;
  logic        tvalid;
  logic        tready;

  modport src (output tdata, tkeep, tlast, tvalid, input tready);
  modport snk (input tdata, tkeep, tlast, tvalid, output tready);
endinterface

// File: design/stream_fifo.sv
/* synchronous word FIFO for the tx and rx streams
   a valid word that meets a full buffer is not stored and pulses overflow */
`timescale 1ns/100ps
`include "link_config.svh"

module stream_fifo (
  input  logic aurora_user_clk,
  input  logic arst_n,
  axis_if.snk  in,
  axis_if.src  out,
  output logic overflow                 // one-cycle pulse per refused word
);

  logic [36:0] mem [`LINK_FIFO_DEPTH];  // {last, keep, data}
  logic [$clog2(`LINK_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(`LINK_FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(`LINK_FIFO_DEPTH):0]   count;
  logic full;
  logic init_done;                      // low until the first clock out of reset
  logic wr_en;
  logic rd_en;

  assign full  = (count == `LINK_FIFO_DEPTH);
  assign wr_en = in.tvalid && in.tready;
  assign rd_en = out.tvalid && out.tready;

  assign in.tready  = init_done && !full;
  assign out.tvalid = (count != 0);
  assign {out.tlast, out.tkeep, out.tdata} = mem[rd_ptr]; // head word

  // word storage
  always_ff @(posedge aurora_user_clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= {in.tlast, in.tkeep, in.tdata};
  end

  always_ff @(posedge aurora_user_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      overflow  <= 1'b0;
      init_done <= 1'b0;
    end
    else
    begin
      init_done <= 1'b1;
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // both or neither
      endcase
      overflow <= in.tvalid && full;    // on tx side this is only a stall
    end
  end

  // a full buffer that is not read keeps its head word
  a_no_write_full: assert property (@(posedge aurora_user_clk) disable iff (!arst_n)
    full && !rd_en |=> full && $stable({out.tlast, out.tkeep, out.tdata}))
    else $error("stream_fifo wrote while full");

endmodule

// File: design/lane_tx.sv
/* lane framer that packs stream words into lane words
   sends idles between packets and a CC word every CC period once the channel is up */
`timescale 1ns/100ps
`include "link_config.svh"

module lane_tx (
  input  logic                   aurora_user_clk,
  input  logic                   arst_n,
  axis_if.snk                    in,
  input  logic                   channel_up,
  output link_pkg::lane_word_t   lane
);
  import link_pkg::*;

  logic [$clog2(`LINK_CC_PERIOD)-1:0] cc_cnt;  // CC scheduler
  logic do_cc;
  logic take;
  lane_word_t nxt_word;

  function automatic lane_word_t idle_word();
    lane_word_t w;
    w = '0;
    w.is_ctrl           = 1'b1;
    w.payload.ctrl.kind = IDLE;
    w.payload.ctrl.info = `LINK_IDLE_PATTERN;
    return w;
  endfunction

  assign do_cc     = channel_up && (cc_cnt == `LINK_CC_PERIOD - 1);
  assign in.tready = channel_up && !do_cc;     // hold off data during CC slot
  assign take      = in.tvalid && in.tready;

  // pick CC, data or idle
  always_comb
  begin
    nxt_word = idle_word();
    if (do_cc)
    begin
      nxt_word.payload.ctrl.kind = CC;
      nxt_word.payload.ctrl.info = '0;         // receiver ignores CC info
    end
    else if (take)
    begin
      nxt_word.is_ctrl           = 1'b0;
      nxt_word.payload.data.last = in.tlast;
      nxt_word.payload.data.keep = in.tkeep;
      nxt_word.payload.data.data = in.tdata;
    end
  end

  always_ff @(posedge aurora_user_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cc_cnt <= '0;
      lane   <= idle_word();
    end
    else
    begin
      // counter held in reset while the channel is down
      if (!channel_up || do_cc) cc_cnt <= '0;
      else                      cc_cnt <= cc_cnt + 1'b1;
      lane <= nxt_word;
    end
  end

  // a word held off by a CC slot stays at the source for the next cycle
  a_cc_vs_data: assert property (@(posedge aurora_user_clk) disable iff (!arst_n)
    do_cc && in.tvalid |=> in.tvalid && $stable({in.tlast, in.tkeep, in.tdata}))
    else $error("lane_tx lost a data word under a CC slot");

endmodule

// File: design/lane_rx.sv
/* lane deframer: checks incoming lane words and tracks lane and channel state
   data words go out on the stream only while the lane is up, no back-pressure */
`timescale 1ns/100ps
`include "link_config.svh"

module lane_rx (
  input  logic                 aurora_user_clk,
  input  logic                 arst_n,
  input  link_pkg::lane_word_t lane,
  input  logic                 lane_reset,
  axis_if.src                  out,
  output logic                 lane_up,
  output logic                 channel_up,
  output logic                 frame_err_pulse,
  output logic [15:0]          err_count
);
  import link_pkg::*;

  logic [$clog2(`LINK_LANE_UP_COUNT):0] idle_cnt;  // good idles in a row
  logic lane_up_r;                                 // first slack stage
  logic good_idle;
  logic bad_word;
  logic is_data;

  // control view of the payload
  assign good_idle = lane.is_ctrl && (lane.payload.ctrl.kind == IDLE)
                     && (lane.payload.ctrl.info == `LINK_IDLE_PATTERN);
  assign bad_word  = lane.is_ctrl && !good_idle && (lane.payload.ctrl.kind != CC);
  assign is_data   = !lane.is_ctrl;

  always_ff @(posedge aurora_user_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      idle_cnt        <= '0;
      lane_up         <= 1'b0;
      lane_up_r       <= 1'b0;
      channel_up      <= 1'b0;
      frame_err_pulse <= 1'b0;
      err_count       <= '0;
      out.tvalid      <= 1'b0;
    end
    else
    begin
      if (bad_word || lane_reset)
      begin
        idle_cnt <= '0;                 // restart training
        lane_up  <= 1'b0;
      end
      else if (!lane_up)
      begin
        if (!good_idle)
          idle_cnt <= '0;               // run broken
        else if (idle_cnt == `LINK_LANE_UP_COUNT - 1)
          lane_up <= 1'b1;
        else
          idle_cnt <= idle_cnt + 1'b1;
      end
      lane_up_r  <= lane_up;            // slack registers
      channel_up <= lane_up_r;
      frame_err_pulse <= bad_word;
      if (bad_word && (err_count != 16'hffff))
        err_count <= err_count + 1'b1;  // saturates
      out.tvalid <= is_data && lane_up; // drop data while lane is down
    end
  end

  // payload, data view
  always_ff @(posedge aurora_user_clk)
  begin
    out.tdata <= lane.payload.data.data;
    out.tkeep <= lane.payload.data.keep;
    out.tlast <= lane.payload.data.last;
  end

  // forwarded data only while the lane is up, apart from a lane_reset edge
  a_data_needs_lane: assert property (@(posedge aurora_user_clk) disable iff (!arst_n)
    out.tvalid |-> lane_up || $past(lane_reset))
    else $error("lane_rx forwarded data with lane down");

endmodule

// File: design/link_regs.sv
/* AXI4-Lite register block: CTRL, STATUS and ERRCNT
   AW and W are taken together, responses are always OKAY */
`timescale 1ns/100ps

module link_regs (
  input  logic        aurora_user_clk,
  input  logic        arst_n,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic        lane_up,
  input  logic        channel_up,
  input  logic        frame_err_pulse,
  input  logic        overflow,
  input  logic [15:0] err_count,
  output logic        loopback,
  output logic        lane_reset
);

  logic [1:0]  ctrl_q;                  // bit0 loopback, bit1 lane_reset
  logic        frame_err_s;             // sticky
  logic        overflow_s;              // sticky
  logic        wr_go;
  logic [31:0] rd_word;

  assign awready    = awvalid && wvalid && !bvalid;
  assign wready     = awready;
  assign wr_go      = awready;          // AW and W in one beat
  assign arready    = !rvalid;
  assign bresp      = 2'b00;
  assign rresp      = 2'b00;
  assign loopback   = ctrl_q[0];
  assign lane_reset = ctrl_q[1];

  always_comb
  begin
    case (araddr)
      4'h0:    rd_word = {30'b0, ctrl_q};
      4'h4:    rd_word = {28'b0, overflow_s, frame_err_s, channel_up, lane_up};
      4'h8:    rd_word = {16'b0, err_count};
      default: rd_word = '0;            // unmapped
    endcase
  end

  always_ff @(posedge aurora_user_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl_q      <= '0;
      frame_err_s <= 1'b0;
      overflow_s  <= 1'b0;
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
      rdata       <= '0;
    end
    else
    begin
      if (wr_go && (awaddr == 4'h0)) ctrl_q <= wdata[1:0];
      // write-1-to-clear, a new event wins
      if (frame_err_pulse)                          frame_err_s <= 1'b1;
      else if (wr_go && (awaddr == 4'h4) && wdata[2]) frame_err_s <= 1'b0;
      if (overflow)                                 overflow_s <= 1'b1;
      else if (wr_go && (awaddr == 4'h4) && wdata[3]) overflow_s <= 1'b0;
      if (wr_go)       bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (arvalid && arready)
      begin
        rvalid <= 1'b1;
        rdata  <= rd_word;
      end
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  a_bvalid_hold: assert property (@(posedge aurora_user_clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid)
    else $error("link_regs dropped bvalid before bready");

endmodule

// File: design/channel_link_top.sv
/* one end of the point-to-point channel: tx FIFO, framer, deframer, rx FIFO
   registers pick loopback and report lane status, all on aurora_user_clk */
`timescale 1ns/100ps

module channel_link_top (
  input  logic                  aurora_user_clk,
  input  logic                  arst_n,
  input  logic [31:0]           tx_tdata,
  input  logic [3:0]            tx_tkeep,
  input  logic                  tx_tlast,
  input  logic                  tx_tvalid,
  output logic                  tx_tready,
  output logic [31:0]           rx_tdata,
  output logic [3:0]            rx_tkeep,
  output logic                  rx_tlast,
  output logic                  rx_tvalid,
  input  logic                  rx_tready,
  output link_pkg::lane_word_t  lane_tx,
  input  link_pkg::lane_word_t  lane_rx,
  input  logic [3:0]            awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [31:0]           wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [3:0]            araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic                  channel_up
);
  import link_pkg::*;

  lane_word_t framer_lane;              // framer output, also loopback source
  lane_word_t rx_lane_sel;
  logic lane_up, frame_err_pulse, overflow, loopback, lane_reset;
  logic [15:0] err_count;

  axis_if tx_host ();                   // user side of tx FIFO
  axis_if tx_link ();
  axis_if rx_link ();
  axis_if rx_host ();                   // user side of rx FIFO

  assign tx_host.tdata  = tx_tdata;
  assign tx_host.tkeep  = tx_tkeep;
  assign tx_host.tlast  = tx_tlast;
  assign tx_host.tvalid = tx_tvalid;
  assign tx_tready      = tx_host.tready;
  assign rx_tdata       = rx_host.tdata;
  assign rx_tkeep       = rx_host.tkeep;
  assign rx_tlast       = rx_host.tlast;
  assign rx_tvalid      = rx_host.tvalid;
  assign rx_host.tready = rx_tready;

  assign lane_tx     = framer_lane;
  assign rx_lane_sel = loopback ? framer_lane : lane_rx;  // near-end loopback

  stream_fifo u_tx_fifo (.aurora_user_clk, .arst_n, .in(tx_host), .out(tx_link), .overflow());

  lane_tx u_framer (.aurora_user_clk, .arst_n, .in(tx_link), .channel_up, .lane(framer_lane));

  lane_rx u_deframer (.aurora_user_clk, .arst_n, .lane(rx_lane_sel), .lane_reset,
                      .out(rx_link), .lane_up, .channel_up, .frame_err_pulse, .err_count);

  // no back-pressure toward the lane, full FIFO drops
  stream_fifo u_rx_fifo (.aurora_user_clk, .arst_n, .in(rx_link), .out(rx_host), .overflow);

  link_regs u_regs (.aurora_user_clk, .arst_n, .awaddr, .awvalid, .awready, .wdata, .wvalid,
                    .wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata,
                    .rresp, .rvalid, .rready, .lane_up, .channel_up, .frame_err_pulse,
                    .overflow, .err_count, .loopback, .lane_reset);

endmodule

// File: tests/channel_link_tb.sv
/* testbench for channel_link_top with a lane model, AXI4-Lite and stream stimulus
   assertions compare every response against values built from the sent traffic */
`timescale 1ns/100ps
`include "link_config.svh"

module channel_link_tb;
  import link_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int N_PKTS        = 24;
  localparam int LANE_UP_LIMIT = `LINK_LANE_UP_COUNT + 4;
  // two round trips at up to 8 cycles a word, register traffic, bring-ups, CC slack
  localparam int WORST_CYCLES  = 2 * N_PKTS * 8 * 8 + 60 * 8 + 4 * (LANE_UP_LIMIT + 8)
                                 + 8 * `LINK_CC_PERIOD;

  typedef enum logic [1:0] {LANE_QUIET, LANE_CLOSED, LANE_BROKEN} lane_mode_e;

  logic aurora_user_clk;
  logic arst_n;
  logic [31:0] tx_tdata, rx_tdata, wdata, rdata;
  logic [3:0]  tx_tkeep, rx_tkeep, awaddr, araddr;
  logic tx_tlast, tx_tvalid, tx_tready, rx_tlast, rx_tvalid, rx_tready;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, channel_up;
  logic [1:0] bresp, rresp;
  lane_word_t lane_out;                       // DUT lane_tx
  lane_word_t lane_in = '0;                   // DUT lane_rx driven by the lane model
  lane_mode_e lane_mode = LANE_QUIET;
  bit corrupt_req, corrupt_ack;
  logic lane_up_d1, lane_up_d2;
  logic [36:0] sb_q [$];                      // sent words as {last, keep, data}
  bit sending;
  bit err_seen;
  int seed = 54637;
  string test_name = "init";

  channel_link_top u_dut (
    .aurora_user_clk, .arst_n, .tx_tdata, .tx_tkeep, .tx_tlast, .tx_tvalid, .tx_tready,
    .rx_tdata, .rx_tkeep, .rx_tlast, .rx_tvalid, .rx_tready, .lane_tx(lane_out),
    .lane_rx(lane_in), .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp,
    .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .channel_up);

  initial
  begin
    aurora_user_clk = 1'b0;
    forever #(CLK_PERIOD / 2) aurora_user_clk = ~aurora_user_clk;
  end

  // lane model with one register of wire delay
  always @(posedge aurora_user_clk)
  begin
    lane_word_t w;
    w = lane_out;
    if (lane_mode == LANE_QUIET)
    begin
      w = '0;
      w.is_ctrl = 1'b1;
      w.payload.ctrl.kind = CC;               // untrained lane sends no idles yet
    end
    else if (lane_mode == LANE_BROKEN)
    begin
      w.is_ctrl = 1'b1;
      w.payload = '1;                         // illegal kind every cycle
    end
    if (corrupt_req != corrupt_ack)
    begin
      w.is_ctrl = 1'b1;
      w.payload.ctrl.kind = IDLE;
      w.payload.ctrl.info = ~`LINK_IDLE_PATTERN; // one damaged idle
      corrupt_ack <= corrupt_req;
    end
    lane_in <= w;
  end

  always @(posedge aurora_user_clk)
  begin
    lane_up_d1 <= u_dut.lane_up;              // two-stage copy of internal lane_up
    lane_up_d2 <= lane_up_d1;
  end

  a_channel_slack: assert property (@(posedge aurora_user_clk) disable iff (!arst_n)
    channel_up == lane_up_d2)
    else fail_run($sformatf("[ERROR] %s: channel_up expected %0b actual %0b", test_name,
                            $sampled(lane_up_d2), $sampled(channel_up)));

  task automatic fail_run(input string msg);
    err_seen = 1'b1;
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act)
      else fail_run($sformatf("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
                              test_name, what, exp, act));
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(posedge aurora_user_clk);
    while (!(awready && wready)) @(posedge aurora_user_clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge aurora_user_clk);
    while (!bvalid) @(posedge aurora_user_clk);  // bready held high
    check_eq("bresp", 64'd0, bresp);
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge aurora_user_clk);
    while (!arready) @(posedge aurora_user_clk);
    arvalid <= 1'b0;
    @(posedge aurora_user_clk);
    while (!rvalid) @(posedge aurora_user_clk);
    check_eq("rresp", 64'd0, rresp);
    data = rdata;
  endtask

  task automatic wait_channel(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (channel_up !== level && n < max_cycles)
    begin
      @(posedge aurora_user_clk);
      n++;
    end
    check_eq("channel_up", level, channel_up);
  endtask

  task automatic send_packet(input int len);
    logic [36:0] w;
    for (int i = 0; i < len; i++)
    begin
      w[36]    = (i == len - 1);
      w[35:32] = w[36] ? (4'($random(seed)) | 4'h1) : 4'hf;  // partial keep on last
      w[31:0]  = $random(seed);
      sb_q.push_back(w);
      {tx_tlast, tx_tkeep, tx_tdata} <= w;
      tx_tvalid <= 1'b1;
      @(posedge aurora_user_clk);
      while (!tx_tready) @(posedge aurora_user_clk);
      tx_tvalid <= 1'b0;
      @(posedge aurora_user_clk);             // pace below rx drain rate
    end
  endtask

  task automatic send_random(input int n_pkts);
    for (int p = 0; p < n_pkts; p++)
      send_packet(($random(seed) & 7) + 1);
    sending = 1'b0;
  endtask

  // with gaps set the received words only need to be an in-order subsequence
  task automatic collect(input bit gaps, input bit rand_ready);
    logic [36:0] got;
    while (sending || sb_q.size() != 0)
    begin
      @(posedge aurora_user_clk);
      if (rx_tvalid && rx_tready)
      begin
        got = {rx_tlast, rx_tkeep, rx_tdata};
        if (gaps)
          while (sb_q.size() > 1 && sb_q[0] != got) void'(sb_q.pop_front());
        assert (sb_q.size() != 0)
          else fail_run("rx delivered a word that was never sent");
        check_eq("rx {last,keep,data}", sb_q[0], got);
        void'(sb_q.pop_front());
      end
      rx_tready <= rand_ready ? (($random(seed) & 3) != 0) : 1'b1;  // mostly ready
    end
  endtask

  initial
  begin
    #(WORST_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before all tests finished");
  end

  initial
  begin
    logic [31:0] rd;
    logic [31:0] errs_before;
    arst_n    = 1'b0;
    tx_tdata  = '0;
    tx_tkeep  = '0;
    tx_tlast  = 1'b0;
    tx_tvalid = 1'b0;
    rx_tready = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    repeat (5) @(posedge aurora_user_clk);
    arst_n <= 1'b1;
    @(posedge aurora_user_clk);

    test_name = "reset_state";
    check_eq("rx_tvalid", 64'd0, rx_tvalid);
    check_eq("tx_tready", 64'd0, tx_tready);
    check_eq("lane_tx is_ctrl", 64'd1, lane_out.is_ctrl);
    check_eq("lane_tx kind", IDLE, lane_out.payload.ctrl.kind);
    axi_read(4'h0, rd);
    check_eq("CTRL", 64'd0, rd);
    axi_read(4'h4, rd);
    check_eq("STATUS", 64'd0, rd);
    axi_read(4'h8, rd);
    check_eq("ERRCNT", 64'd0, rd);

    test_name = "bring_up";
    lane_mode <= LANE_CLOSED;
    wait_channel(1'b1, LANE_UP_LIMIT);
    axi_read(4'h4, rd);
    check_eq("STATUS", 64'h3, rd);

    test_name = "round_trip";
    sending = 1'b1;
    fork
      send_random(N_PKTS);
      collect(1'b0, 1'b1);
    join
    rx_tready <= 1'b1;

    test_name = "corrupt_idle";
    axi_read(4'h8, errs_before);
    corrupt_req <= ~corrupt_req;
    wait_channel(1'b0, 8);
    axi_read(4'h8, rd);
    check_eq("ERRCNT", errs_before + 1, rd);
    axi_read(4'h4, rd);
    check_eq("STATUS frame_err", 64'd1, rd[2]);
    axi_write(4'h4, 32'h4);                   // write 1 to clear
    axi_read(4'h4, rd);
    check_eq("STATUS frame_err", 64'd0, rd[2]);
    wait_channel(1'b1, LANE_UP_LIMIT);
    axi_read(4'h4, rd);
    check_eq("STATUS", 64'h3, rd);

    test_name = "loopback";
    lane_mode <= LANE_BROKEN;
    wait_channel(1'b0, 8);
    axi_write(4'h0, 32'h1);
    wait_channel(1'b1, LANE_UP_LIMIT);
    axi_read(4'h0, rd);
    check_eq("CTRL", 64'h1, rd);
    sending = 1'b1;
    fork
      send_random(N_PKTS);
      collect(1'b0, 1'b1);
    join

    test_name = "rx_overflow";
    rx_tready <= 1'b0;
    repeat (3) send_packet(8);                // more than the rx FIFO holds
    axi_read(4'h4, rd);
    check_eq("STATUS overflow", 64'd1, rd[3]);
    sending = 1'b1;
    fork
      begin
        send_packet(2);                       // marker that must arrive
        sending = 1'b0;
      end
      collect(1'b1, 1'b0);
    join

    if (err_seen == 1'b0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/link_pkg.sv
design/axis_if.sv
design/stream_fifo.sv
design/lane_tx.sv
design/lane_rx.sv
design/link_regs.sv
design/channel_link_top.sv
tests/channel_link_tb.sv

// File: Makefile
# Verilator build and run of the channel link testbench
TOP    ?= channel_link_tb
FLIST  ?= verilog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
